// File: sim.f
common/frontend_pkg.sv
src/imm_decoder.sv
predictor/branch_predict.sv
predictor/predict_ctrl.sv
src/fetch_unit.sv
src/frontend_top.sv
verification/tb_frontend.sv

// File: Bender.yml
package:
  name: rv32i_frontend

sources:
  - common/frontend_pkg.sv
  - src/imm_decoder.sv
  - predictor/branch_predict.sv
  - predictor/predict_ctrl.sv
  - src/fetch_unit.sv
  - src/frontend_top.sv
  - target: test
    files:
      - verification/tb_frontend.sv

// File: verification/tb_frontend.sv
// Directed testbench for the fetch front-end with instruction memory model, compare task and tests
`timescale 1ns/100ps

module tb_frontend;
    import frontend_pkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT = 50;

    logic       clk;
    logic       rst_n;
    logic       imem_req_valid;
    logic       imem_req_ready;
    fetch_req_t imem_req;
    logic       imem_rsp_valid;
    logic       imem_rsp_ready;
    fetch_rsp_t imem_rsp;
    logic       pkt_valid;
    logic       pkt_ready;
    fetch_pkt_t pkt;
    logic       redirect_valid;
    redirect_t  redirect;
    logic       cfg_we;
    cfg_addr_t  cfg_addr;
    xlen_t      cfg_wdata;
    xlen_t      cfg_rdata;

    // Word memory of 4 KiB
    xlen_t mem [0:1023];

    string cur_test;
    int    errors;
    int    checks;
    int    test_start_errors;
    int    tests_run;
    int    tests_failed;
    // Expected counter values
    int    tally_pred;
    int    tally_taken;
    int    tally_redir;

    frontend_top i_frontend_top (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .imem_req_valid_o (imem_req_valid),
        .imem_req_ready_i (imem_req_ready),
        .imem_req_o       (imem_req),
        .imem_rsp_valid_i (imem_rsp_valid),
        .imem_rsp_ready_o (imem_rsp_ready),
        .imem_rsp_i       (imem_rsp),
        .pkt_valid_o      (pkt_valid),
        .pkt_ready_i      (pkt_ready),
        .pkt_o            (pkt),
        .redirect_valid_i (redirect_valid),
        .redirect_i       (redirect),
        .cfg_we_i         (cfg_we),
        .cfg_addr_i       (cfg_addr),
        .cfg_wdata_i      (cfg_wdata),
        .cfg_rdata_o      (cfg_rdata)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Plain ALU word (opcode 0x13) with upper bits spread from the address
    function automatic xlen_t fill_word(input xlen_t addr);
        fill_word = {addr[24:0] ^ addr[31:7], 7'h13};
    endfunction

    // RV32I J-type with rd = x0
    function automatic xlen_t encode_jal(input xlen_t imm);
        encode_jal = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPC_JAL};
    endfunction

    // BEQ x0, x0
    function automatic xlen_t encode_branch(input xlen_t imm);
        encode_branch = {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // Memory model
    // Ready always high and response after 0 to 3 cycles
    initial begin : imem_model
        logic  req_seen;
        logic  rsp_seen;
        logic  pending;
        xlen_t seen_addr;
        xlen_t req_addr;
        int    delay;
        imem_req_ready = 1'b1;
        imem_rsp_valid = 1'b0;
        imem_rsp       = '0;
        pending        = 1'b0;
        req_addr       = '0;
        delay          = 0;
        forever begin
            // Handshakes sampled mid-cycle
            @(negedge clk);
            req_seen  = imem_req_valid && imem_req_ready;
            rsp_seen  = imem_rsp_valid && imem_rsp_ready;
            seen_addr = imem_req.addr;
            @(posedge clk);
            #10;
            if (rsp_seen) begin
                imem_rsp_valid = 1'b0;
                imem_rsp       = '0;
            end
            if (req_seen) begin
                pending  = 1'b1;
                req_addr = seen_addr;
                delay    = $urandom % 4;
            end
            if (pending) begin
                if (delay == 0) begin
                    imem_rsp_valid = 1'b1;
                    imem_rsp.instr = mem[req_addr[11:2]];
                    pending        = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic compare(input string what, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            $display("FAILED %s %s: expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
    endtask

    task automatic end_test;
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", cur_test, errors - test_start_errors);
    endtask

    // All tasks below start and end 10 ns after a rising edge
    task automatic drive_redirect(input xlen_t target);
        redirect_valid = 1'b1;
        redirect.pc    = target;
        @(posedge clk);
        #10;
        redirect_valid = 1'b0;
        tally_redir++;
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input xlen_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #10;
        cfg_we    = 1'b0;
    endtask

    task automatic read_cfg(input cfg_addr_t addr, output xlen_t data);
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
        @(posedge clk);
        #10;
    endtask

    // Raise decode ready until one packet transfers
    task automatic receive_packet(output fetch_pkt_t got_pkt, output logic got);
        int cycles;
        cycles    = 0;
        got       = 1'b0;
        got_pkt   = '0;
        pkt_ready = 1'b1;
        while (!got && (cycles < TIMEOUT)) begin
            @(negedge clk);
            if (pkt_valid) begin
                got_pkt = pkt;
                got     = 1'b1;
            end
            @(posedge clk);
            #10;
            cycles++;
        end
        pkt_ready = 1'b0;
        if (!got) begin
            $display("timeout in test %s: no decode packet within %0d cycles", cur_test, TIMEOUT);
            errors++;
        end
    endtask

    // Instruction expected from the memory image
    task automatic expect_packet(input string what, input xlen_t exp_pc, input logic exp_taken,
                                 input xlen_t exp_target, input logic check_target);
        fetch_pkt_t got_pkt;
        logic       got;
        xlen_t      exp_instr;
        receive_packet(got_pkt, got);
        if (got) begin
            exp_instr = mem[exp_pc[11:2]];
            compare({what, " pc"}, exp_pc, got_pkt.pc);
            compare({what, " instr"}, exp_instr, got_pkt.instr);
            compare({what, " taken"}, xlen_t'(exp_taken), xlen_t'(got_pkt.pred_taken));
            if (check_target) begin
                compare({what, " target"}, exp_target, got_pkt.pred_target);
            end
            if ((exp_instr[6:0] == OPC_JAL) || (exp_instr[6:0] == OPC_BRANCH)) begin
                tally_pred++;
                if (exp_taken) begin
                    tally_taken++;
                end
            end
        end
    endtask

    // Returns just after a request transfer with the response pending
    task automatic wait_request;
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < TIMEOUT)) begin
            @(negedge clk);
            seen = imem_req_valid && imem_req_ready;
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!seen) begin
            $display("timeout in test %s: no memory request within %0d cycles", cur_test, TIMEOUT);
            errors++;
        end
    endtask

    // Decode ready stays low
    task automatic wait_packet_valid;
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < TIMEOUT)) begin
            @(negedge clk);
            seen = pkt_valid;
            @(posedge clk);
            #10;
            cycles++;
        end
        if (!seen) begin
            $display("timeout in test %s: packet valid never rose", cur_test);
            errors++;
        end
    endtask

    task automatic sequential_fetch;
        begin_test("sequential_fetch");
        // Starts straight from the reset PC
        expect_packet("word 0", 32'h0, 1'b0, '0, 1'b0);
        expect_packet("word 1", 32'h4, 1'b0, '0, 1'b0);
        expect_packet("word 2", 32'h8, 1'b0, '0, 1'b0);
        expect_packet("word 3", 32'hc, 1'b0, '0, 1'b0);
        end_test();
    endtask

    task automatic jal_and_branch;
        begin_test("jal_and_branch");
        drive_redirect(32'h100);
        expect_packet("jal", 32'h100, 1'b1, 32'h140, 1'b1);
        expect_packet("back branch", 32'h140, 1'b1, 32'h120, 1'b1);
        expect_packet("fwd branch", 32'h120, 1'b0, '0, 1'b0);
        expect_packet("fall through", 32'h124, 1'b0, '0, 1'b0);
        end_test();
    endtask

    task automatic prediction_disable;
        xlen_t data;
        begin_test("prediction_disable");
        write_cfg(CFG_CTRL, 32'h0);
        read_cfg(CFG_CTRL, data);
        compare("ctrl off", 32'h0, data);
        drive_redirect(32'h100);
        expect_packet("jal", 32'h100, 1'b0, '0, 1'b0);
        expect_packet("after jal", 32'h104, 1'b0, '0, 1'b0);
        drive_redirect(32'h140);
        expect_packet("back branch", 32'h140, 1'b0, '0, 1'b0);
        expect_packet("after branch", 32'h144, 1'b0, '0, 1'b0);
        write_cfg(CFG_CTRL, 32'h1);
        read_cfg(CFG_CTRL, data);
        compare("ctrl on", 32'h1, data);
        end_test();
    endtask

    task automatic redirect_flush;
        begin_test("redirect_flush");
        drive_redirect(32'h200);
        expect_packet("before flush", 32'h200, 1'b0, '0, 1'b0);
        // JAL at 0x204 in flight when the pulse arrives
        wait_request();
        drive_redirect(32'h300);
        expect_packet("redirect pc", 32'h300, 1'b0, '0, 1'b0);
        expect_packet("after redirect", 32'h304, 1'b0, '0, 1'b0);
        end_test();
    endtask

    task automatic backpressure_hold;
        begin_test("backpressure_hold");
        drive_redirect(32'h400);
        wait_packet_valid();
        repeat (8) begin
            @(negedge clk);
            compare("valid held", 32'h1, xlen_t'(pkt_valid));
            compare("pc held", 32'h400, pkt.pc);
            compare("instr held", mem[32'h400 >> 2], pkt.instr);
            compare("no request", 32'h0, xlen_t'(imem_req_valid));
            @(posedge clk);
            #10;
        end
        expect_packet("stalled", 32'h400, 1'b0, '0, 1'b0);
        expect_packet("next", 32'h404, 1'b0, '0, 1'b0);
        expect_packet("next again", 32'h408, 1'b0, '0, 1'b0);
        end_test();
    endtask

    task automatic counter_readback;
        xlen_t data;
        begin_test("counter_readback");
        read_cfg(CFG_PRED_CNT, data);
        compare("pred count", xlen_t'(tally_pred), data);
        read_cfg(CFG_TAKEN_CNT, data);
        compare("taken count", xlen_t'(tally_taken), data);
        read_cfg(CFG_REDIR_CNT, data);
        compare("redirect count", xlen_t'(tally_redir), data);
        end_test();
    endtask

    initial begin
        void'($urandom(19872));
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        tally_pred   = 0;
        tally_taken  = 0;
        tally_redir  = 0;
        rst_n          = 1'b0;
        pkt_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect       = '0;
        cfg_we         = 1'b0;
        cfg_addr       = CFG_CTRL;
        cfg_wdata      = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(xlen_t'(i) << 2);
        end
        // Control-flow words
        mem[32'h100 >> 2] = encode_jal(32'h40);
        mem[32'h140 >> 2] = encode_branch(-32'sd32);
        mem[32'h120 >> 2] = encode_branch(32'h10);
        mem[32'h204 >> 2] = encode_jal(32'h80);
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;
        sequential_fetch();
        jal_and_branch();
        prediction_disable();
        redirect_flush();
        backpressure_hold();
        counter_readback();
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src/frontend_top.sv
// Front-end top with fetch unit, immediate decoder, static predictor and cfg block
`timescale 1ns/100ps

module frontend_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // Instruction memory
    output logic                     imem_req_valid_o,
    input  logic                     imem_req_ready_i,
    output frontend_pkg::fetch_req_t imem_req_o,
    input  logic                     imem_rsp_valid_i,
    output logic                     imem_rsp_ready_o,
    input  frontend_pkg::fetch_rsp_t imem_rsp_i,
    // Decode
    output logic                     pkt_valid_o,
    input  logic                     pkt_ready_i,
    output frontend_pkg::fetch_pkt_t pkt_o,
    // Back-end flush
    input  logic                     redirect_valid_i,
    input  frontend_pkg::redirect_t  redirect_i,
    // Cfg register port
    input  logic                     cfg_we_i,
    input  frontend_pkg::cfg_addr_t  cfg_addr_i,
    input  frontend_pkg::xlen_t      cfg_wdata_i,
    output frontend_pkg::xlen_t      cfg_rdata_o
);
    import frontend_pkg::*;

    xlen_t fetch_pc;
    xlen_t fetch_instr;
    xlen_t imm_b;
    xlen_t imm_j;
    logic  is_jal;
    logic  is_branch;
    logic  predict_taken;
    xlen_t predict_target;
    logic  predict_enable;
    logic  pred_event;
    logic  pred_taken;

    fetch_unit i_fetch_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .imem_req_valid_o (imem_req_valid_o),
        .imem_req_ready_i (imem_req_ready_i),
        .imem_req_o       (imem_req_o),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_ready_o (imem_rsp_ready_o),
        .imem_rsp_i       (imem_rsp_i),
        .pkt_valid_o      (pkt_valid_o),
        .pkt_ready_i      (pkt_ready_i),
        .pkt_o            (pkt_o),
        .redirect_valid_i (redirect_valid_i),
        .redirect_i       (redirect_i),
        .fetch_pc_o       (fetch_pc),
        .fetch_instr_o    (fetch_instr),
        .predict_taken_i  (predict_taken),
        .predict_target_i (predict_target),
        .pred_event_o     (pred_event),
        .pred_taken_o     (pred_taken)
    );

    // Decoder sees the word while its response transfers
    imm_decoder i_imm_decoder (
        .instr_i     (fetch_instr),
        .imm_b_o     (imm_b),
        .imm_j_o     (imm_j),
        .is_jal_o    (is_jal),
        .is_branch_o (is_branch)
    );

    branch_predict i_branch_predict (
        .pc_i             (fetch_pc),
        .is_jal_i         (is_jal),
        .is_branch_i      (is_branch),
        .imm_b_i          (imm_b),
        .imm_j_i          (imm_j),
        .enable_i         (predict_enable),
        .predict_taken_o  (predict_taken),
        .predict_target_o (predict_target)
    );

    // Every redirect pulse is counted
    predict_ctrl i_predict_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .cfg_rdata_o      (cfg_rdata_o),
        .enable_o         (predict_enable),
        .pred_event_i     (pred_event),
        .pred_taken_i     (pred_taken),
        .redirect_event_i (redirect_valid_i)
    );

endmodule

// File: src/fetch_unit.sv
// PC register, fetch FSM, imem request/response handshakes, redirect flush and decode packet
`timescale 1ns/100ps

module fetch_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    output logic                     imem_req_valid_o,
    input  logic                     imem_req_ready_i,
    output frontend_pkg::fetch_req_t imem_req_o,
    input  logic                     imem_rsp_valid_i,
    output logic                     imem_rsp_ready_o,
    input  frontend_pkg::fetch_rsp_t imem_rsp_i,
    output logic                     pkt_valid_o,
    input  logic                     pkt_ready_i,
    output frontend_pkg::fetch_pkt_t pkt_o,
    input  logic                     redirect_valid_i,
    input  frontend_pkg::redirect_t  redirect_i,
    output frontend_pkg::xlen_t      fetch_pc_o,
    output frontend_pkg::xlen_t      fetch_instr_o,
    input  logic                     predict_taken_i,
    input  frontend_pkg::xlen_t      predict_target_i,
    output logic                     pred_event_o,
    output logic                     pred_taken_o
);
    import frontend_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    xlen_t        pc_q;
    xlen_t        pc_d;
    logic         req_valid_q;
    fetch_pkt_t   pkt_q;
    logic         req_fire;
    logic         rsp_fire;
    logic         pkt_fire;
    logic         pkt_latch;
    opcode_t      pkt_opcode;
    logic         pkt_is_cf;

    // Channel transfers
    assign req_fire = imem_req_valid_o && imem_req_ready_i;
    assign rsp_fire = imem_rsp_valid_i && imem_rsp_ready_o;
    assign pkt_fire = pkt_valid_o && pkt_ready_i;

    // Fresh word with no flush in the same cycle
    assign pkt_latch = (state_q == FETCH_WAIT) && rsp_fire && !redirect_valid_i;

    // Next state and next PC
    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        unique case (state_q)
            FETCH_REQ: begin
                if (req_fire) begin
                    state_d = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                // Follow the prediction made on this word
                if (rsp_fire) begin
                    state_d = FETCH_OUT;
                    pc_d    = predict_taken_i ? predict_target_i : pc_q + PC_STEP;
                end
            end
            FETCH_OUT: begin
                // Hold under back-pressure, no new request
                if (pkt_fire) begin
                    state_d = FETCH_REQ;
                end
            end
            FETCH_DROP: begin
                if (rsp_fire) begin
                    state_d = FETCH_REQ;
                end
            end
            default: begin
                state_d = FETCH_REQ;
            end
        endcase
        // Redirect overrides everything
        // A request still in flight has to be drained first
        if (redirect_valid_i) begin
            pc_d = redirect_i.pc;
            if ((state_q == FETCH_REQ) && req_fire) begin
                state_d = FETCH_DROP;
            end else if (((state_q == FETCH_WAIT) || (state_q == FETCH_DROP)) && !rsp_fire) begin
                state_d = FETCH_DROP;
            end else begin
                state_d = FETCH_REQ;
            end
        end
    end

    // Control state
    // req_valid_q rises in the first cycle of FETCH_REQ
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= FETCH_REQ;
            pc_q        <= RESET_PC;
            req_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            pc_q        <= pc_d;
            req_valid_q <= (state_d == FETCH_REQ);
        end
    end

    // Packet payload with the prediction of its word
    always_ff @(posedge clk_i) begin
        if (pkt_latch) begin
            pkt_q.pc          <= pc_q;
            pkt_q.instr       <= imem_rsp_i.instr;
            pkt_q.pred_taken  <= predict_taken_i;
            pkt_q.pred_target <= predict_target_i;
        end
    end

    // Memory side
    assign imem_req_valid_o = req_valid_q;
    assign imem_req_o.addr  = pc_q;
    assign imem_rsp_ready_o = (state_q == FETCH_WAIT) || (state_q == FETCH_DROP);

    // Word under prediction goes straight to decoder and predictor
    assign fetch_pc_o    = pc_q;
    assign fetch_instr_o = imem_rsp_i.instr;

    // Decode side
    assign pkt_valid_o = (state_q == FETCH_OUT);
    assign pkt_o       = pkt_q;

    // Statistics event on delivery of a control-flow word
    assign pkt_opcode   = pkt_q.instr[6:0];
    assign pkt_is_cf    = (pkt_opcode == OPC_JAL) || (pkt_opcode == OPC_BRANCH);
    assign pred_event_o = pkt_fire && pkt_is_cf;
    assign pred_taken_o = pred_event_o && pkt_q.pred_taken;

    // Request held stable until accepted, unless flushed
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_req_valid_o && !imem_req_ready_i && !redirect_valid_i
        |=> imem_req_valid_o && $stable(imem_req_o))
        else $error("fetch_unit: request dropped or changed before transfer");

    // Packet held stable under decode back-pressure, unless flushed
    a_pkt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pkt_valid_o && !pkt_ready_i && !redirect_valid_i
        |=> pkt_valid_o && $stable(pkt_o))
        else $error("fetch_unit: packet dropped or changed under back-pressure");

endmodule

// File: predictor/predict_ctrl.sv
// Cfg registers with prediction enable and prediction, taken and redirect counters
`timescale 1ns/100ps

module predict_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    cfg_we_i,
    input  frontend_pkg::cfg_addr_t cfg_addr_i,
    input  frontend_pkg::xlen_t     cfg_wdata_i,
    output frontend_pkg::xlen_t     cfg_rdata_o,
    output logic                    enable_o,
    input  logic                    pred_event_i,
    input  logic                    pred_taken_i,
    input  logic                    redirect_event_i
);
    import frontend_pkg::*;

    logic  enable_q;
    xlen_t pred_cnt_q;
    xlen_t taken_cnt_q;
    xlen_t redir_cnt_q;

    // Enable bit, on after reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b1;
        end else if (cfg_we_i && (cfg_addr_i == CFG_CTRL)) begin
            enable_q <= cfg_wdata_i[0];
        end
    end

    // Event counters
    // Any write to a counter address clears it, write beats the event
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pred_cnt_q  <= '0;
            taken_cnt_q <= '0;
            redir_cnt_q <= '0;
        end else begin
            if (cfg_we_i && (cfg_addr_i == CFG_PRED_CNT)) begin
                pred_cnt_q <= '0;
            end else if (pred_event_i) begin
                pred_cnt_q <= pred_cnt_q + 1'b1;
            end
            if (cfg_we_i && (cfg_addr_i == CFG_TAKEN_CNT)) begin
                taken_cnt_q <= '0;
            end else if (pred_event_i && pred_taken_i) begin
                taken_cnt_q <= taken_cnt_q + 1'b1;
            end
            if (cfg_we_i && (cfg_addr_i == CFG_REDIR_CNT)) begin
                redir_cnt_q <= '0;
            end else if (redirect_event_i) begin
                redir_cnt_q <= redir_cnt_q + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        unique case (cfg_addr_i)
            CFG_CTRL:      cfg_rdata_o = {{(XLEN-1){1'b0}}, enable_q};
            CFG_PRED_CNT:  cfg_rdata_o = pred_cnt_q;
            CFG_TAKEN_CNT: cfg_rdata_o = taken_cnt_q;
            default:       cfg_rdata_o = redir_cnt_q;
        endcase
    end

    assign enable_o = enable_q;

endmodule

// File: predictor/branch_predict.sv
// Static taken/not-taken prediction and target adder for one fetched word
`timescale 1ns/100ps

module branch_predict (
    input  frontend_pkg::xlen_t pc_i,
    input  logic                is_jal_i,
    input  logic                is_branch_i,
    input  frontend_pkg::xlen_t imm_b_i,
    input  frontend_pkg::xlen_t imm_j_i,
    input  logic                enable_i,
    output logic                predict_taken_o,
    output frontend_pkg::xlen_t predict_target_o
);
    import frontend_pkg::*;

    xlen_t offset;
    logic  backward;
    logic  taken_raw;

    // Offset selection
    // Non control-flow words get the sequential step
    always_comb begin
        if (is_jal_i) begin
            offset = imm_j_i;
        end else if (is_branch_i) begin
            offset = imm_b_i;
        end else begin
            offset = PC_STEP;
        end
    end

    // Negative branch offset means a loop back edge
    assign backward = imm_b_i[XLEN-1];

    // JAL always taken and a branch only when backward
    assign taken_raw = is_jal_i || (is_branch_i && backward);

    // Prediction switched off from the cfg block
    assign predict_taken_o = enable_i && taken_raw;

    // Target still computed when disabled so decode sees it
    assign predict_target_o = pc_i + offset;

endmodule

// File: src/imm_decoder.sv
// B-type and J-type immediate extraction and control-flow opcode classification
`timescale 1ns/100ps

module imm_decoder (
    input  frontend_pkg::xlen_t instr_i,
    output frontend_pkg::xlen_t imm_b_o,
    output frontend_pkg::xlen_t imm_j_o,
    output logic                is_jal_o,
    output logic                is_branch_o
);
    import frontend_pkg::*;

    opcode_t opcode;
    logic    sign;

    // Major opcode in the low seven bits
    assign opcode = instr_i[6:0];

    // Both formats keep the sign in bit 31
    assign sign = instr_i[31];

    // B-type offset
    // imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    // Bit 0 always zero
    assign imm_b_o = {
        {20{sign}},
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // J-type offset
    // imm[20|10:1|11|19:12] packed into 31:12
    // Bit 0 always zero
    assign imm_j_o = {
        {12{sign}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    // Opcode class
    // JALR is not predicted so it falls into neither class
    assign is_jal_o    = (opcode == OPC_JAL);
    assign is_branch_o = (opcode == OPC_BRANCH);

endmodule

// File: common/frontend_pkg.sv
// Front-end widths, opcodes, fetch/decode packet structs, cfg register map and fetch FSM states
package frontend_pkg;

    // Machine word width for RV32I
    localparam int unsigned XLEN = 32;

    // PC, instruction word and immediate
    typedef logic [XLEN-1:0] xlen_t;

    // Major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // Control-flow opcodes seen by the predictor
    localparam opcode_t OPC_JAL    = 7'h6f;
    localparam opcode_t OPC_BRANCH = 7'h63;

    // Boot address
    localparam xlen_t RESET_PC = 32'h0000_0000;

    // Sequential fetch step, no compressed instructions
    localparam xlen_t PC_STEP = 32'd4;

    // Request to instruction memory
    typedef struct packed {
        xlen_t addr;
    } fetch_req_t;

    // Word returned by instruction memory
    typedef struct packed {
        xlen_t instr;
    } fetch_rsp_t;

    // Packet handed to decode
    typedef struct packed {
        xlen_t pc;
        xlen_t instr;
        logic  pred_taken;
        xlen_t pred_target;
    } fetch_pkt_t;

    // Corrected PC from the back-end
    typedef struct packed {
        xlen_t pc;
    } redirect_t;

    // Cfg register address
    typedef logic [1:0] cfg_addr_t;

    // Cfg register map
    localparam cfg_addr_t CFG_CTRL      = 2'd0;
    localparam cfg_addr_t CFG_PRED_CNT  = 2'd1;
    localparam cfg_addr_t CFG_TAKEN_CNT = 2'd2;
    localparam cfg_addr_t CFG_REDIR_CNT = 2'd3;

    // Fetch FSM
    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_OUT,
        FETCH_DROP
    } fetch_state_e;

endpackage
